//--- src/lockstep_pkg.sv
// Shared widths and types of the data-memory lockstep checker
// Imported by every RTL block that handles addresses, data words or byte enables

package lockstep_pkg;

  // Bus geometry
  parameter int unsigned AddrWidth = 32;
  parameter int unsigned DataWidth = 32;
  parameter int unsigned ByteWidth = 8;  // Bits per byte lane
  parameter int unsigned BeWidth   = DataWidth / ByteWidth;

  // One bus address
  typedef logic [AddrWidth-1:0] addr_t;

  // One data word, no tag bit
  typedef logic [DataWidth-1:0] data_t;

  // One enable per byte lane
  typedef logic [BeWidth-1:0] be_t;

endpackage

//--- src/exp_access_fifo.sv
// Queue of expected accesses announced by the reference model
// The oldest entry is presented as the head, pops come from the comparator
// A push into a full queue is dropped and flagged for one cycle

`timescale 1ns/1ps

module exp_access_fifo #(
  parameter int unsigned ExpDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 push_i,
  input  logic                 we_i,
  input  logic                 split_i,
  input  lockstep_pkg::addr_t  fst_addr_i,
  input  lockstep_pkg::addr_t  snd_addr_i,
  input  lockstep_pkg::data_t  fst_wdata_i,
  input  lockstep_pkg::data_t  snd_wdata_i,
  input  lockstep_pkg::be_t    fst_be_i,
  input  lockstep_pkg::be_t    snd_be_i,
  input  logic                 pop_i,
  output logic                 head_valid_o,
  output logic                 head_we_o,
  output logic                 head_split_o,
  output lockstep_pkg::addr_t  head_fst_addr_o,
  output lockstep_pkg::addr_t  head_snd_addr_o,
  output lockstep_pkg::data_t  head_fst_wdata_o,
  output lockstep_pkg::data_t  head_snd_wdata_o,
  output lockstep_pkg::be_t    head_fst_be_o,
  output lockstep_pkg::be_t    head_snd_be_o,
  output logic                 overflow_o
);
  import lockstep_pkg::*;

  localparam int unsigned PtrWidth   = (ExpDepth > 1) ? $clog2(ExpDepth) : 1;
  localparam int unsigned CountWidth = $clog2(ExpDepth + 1);

  logic [PtrWidth-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CountWidth-1:0] count_q;
  logic                  full, push_en, pop_en;

  // Entry storage, one array per field
  logic  we_mem        [ExpDepth];
  logic  split_mem     [ExpDepth];
  addr_t fst_addr_mem  [ExpDepth];
  addr_t snd_addr_mem  [ExpDepth];
  data_t fst_wdata_mem [ExpDepth];
  data_t snd_wdata_mem [ExpDepth];
  be_t   fst_be_mem    [ExpDepth];
  be_t   snd_be_mem    [ExpDepth];

  assign full         = (count_q == CountWidth'(ExpDepth));
  assign head_valid_o = (count_q != '0);
  assign pop_en       = pop_i & head_valid_o;
  assign push_en      = push_i & (~full | pop_en); // Pop frees the slot this cycle
  assign overflow_o   = push_i & ~push_en;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(ExpDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(ExpDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Idle or both
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      we_mem[wr_ptr_q]        <= we_i;
      split_mem[wr_ptr_q]     <= split_i;
      fst_addr_mem[wr_ptr_q]  <= fst_addr_i;
      snd_addr_mem[wr_ptr_q]  <= snd_addr_i;
      fst_wdata_mem[wr_ptr_q] <= fst_wdata_i;
      snd_wdata_mem[wr_ptr_q] <= snd_wdata_i;
      fst_be_mem[wr_ptr_q]    <= fst_be_i;
      snd_be_mem[wr_ptr_q]    <= snd_be_i;
    end
  end

  // Oldest entry
  assign head_we_o        = we_mem[rd_ptr_q];
  assign head_split_o     = split_mem[rd_ptr_q];
  assign head_fst_addr_o  = fst_addr_mem[rd_ptr_q];
  assign head_snd_addr_o  = snd_addr_mem[rd_ptr_q];
  assign head_fst_wdata_o = fst_wdata_mem[rd_ptr_q];
  assign head_snd_wdata_o = snd_wdata_mem[rd_ptr_q];
  assign head_fst_be_o    = fst_be_mem[rd_ptr_q];
  assign head_snd_be_o    = snd_be_mem[rd_ptr_q];

endmodule

//--- src/access_compare.sv
// Compares each granted bus request against the due part of the head access
// Split accesses are checked first part then second part, the last part pops
// Results come out as registered pulses one cycle after the grant

`timescale 1ns/1ps

module access_compare (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 data_req_i,
  input  logic                 data_gnt_i,
  input  logic                 data_we_i,
  input  lockstep_pkg::addr_t  data_addr_i,
  input  lockstep_pkg::data_t  data_wdata_i,
  input  logic                 head_valid_i,
  input  logic                 head_we_i,
  input  logic                 head_split_i,
  input  lockstep_pkg::addr_t  head_fst_addr_i,
  input  lockstep_pkg::addr_t  head_snd_addr_i,
  input  lockstep_pkg::data_t  head_fst_wdata_i,
  input  lockstep_pkg::data_t  head_snd_wdata_i,
  input  lockstep_pkg::be_t    head_fst_be_i,
  input  lockstep_pkg::be_t    head_snd_be_i,
  output logic                 pop_o,
  output logic                 grant_o,
  output logic                 mismatch_o,
  output logic                 unexpected_o,
  output logic                 done_o
);
  import lockstep_pkg::*;

  logic  gnt;
  logic  checked_gnt;  // Grant with an expected access to check against
  logic  snd_due_q;    // First part of the head already granted
  logic  last_part;
  addr_t part_addr;
  data_t part_wdata;
  be_t   part_be;
  data_t part_mask;
  logic  dir_diff, addr_diff, data_diff;
  logic  part_mismatch;

  assign gnt         = data_req_i & data_gnt_i;
  assign grant_o     = gnt;
  assign checked_gnt = gnt & head_valid_i;
  assign last_part   = ~head_split_i | snd_due_q;
  assign pop_o       = checked_gnt & last_part;

  // Due part of the head
  assign part_addr  = snd_due_q ? head_snd_addr_i  : head_fst_addr_i;
  assign part_wdata = snd_due_q ? head_snd_wdata_i : head_fst_wdata_i;
  assign part_be    = snd_due_q ? head_snd_be_i    : head_fst_be_i;

  // Expand byte enables to a bit mask
  always_comb begin
    part_mask = '0;
    for (int unsigned i = 0; i < BeWidth; i++) begin
      part_mask[i*ByteWidth +: ByteWidth] = {ByteWidth{part_be[i]}};
    end
  end

  assign dir_diff  = (data_we_i != head_we_i);
  assign addr_diff = (data_addr_i != part_addr);
  assign data_diff = head_we_i & (((data_wdata_i ^ part_wdata) & part_mask) != '0);

  assign part_mismatch = dir_diff | addr_diff | data_diff;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      snd_due_q    <= 1'b0;
      mismatch_o   <= 1'b0;
      unexpected_o <= 1'b0;
      done_o       <= 1'b0;
    end else begin
      if (checked_gnt) begin
        snd_due_q <= ~last_part; // Only a first part of a split access leaves one due
      end
      mismatch_o   <= checked_gnt & part_mismatch;
      unexpected_o <= gnt & ~head_valid_i;
      done_o       <= pop_o;
    end
  end

endmodule

//--- src/resp_tracker.sv
// Counts outstanding bus responses and compare mismatches
// Also keeps sticky flags for response underflow and expected-queue overflow
// All outputs follow their events by one clock

`timescale 1ns/1ps

module resp_tracker #(
  parameter int unsigned CntWidth = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                grant_i,
  input  logic                rvalid_i,
  input  logic                mismatch_i,
  input  logic                overflow_i,
  output logic [CntWidth-1:0] outstanding_o,
  output logic [CntWidth-1:0] mismatch_count_o,
  output logic                resp_underflow_o,
  output logic                overflow_o
);

  logic outst_empty;
  logic mismatch_sat;

  assign outst_empty  = (outstanding_o == '0);
  assign mismatch_sat = (mismatch_count_o == '1);

  // Outstanding responses, grant adds and rvalid retires
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_o    <= '0;
      resp_underflow_o <= 1'b0;
    end else begin
      case ({grant_i, rvalid_i})
        2'b10: outstanding_o <= outstanding_o + 1'b1;
        2'b01: begin
          if (outst_empty) begin
            resp_underflow_o <= 1'b1; // Response with nothing in flight
          end else begin
            outstanding_o <= outstanding_o - 1'b1;
          end
        end
        default: outstanding_o <= outstanding_o;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mismatch_count_o <= '0;
      overflow_o       <= 1'b0;
    end else begin
      if (mismatch_i && !mismatch_sat) begin
        mismatch_count_o <= mismatch_count_o + 1'b1;
      end
      if (overflow_i) begin
        overflow_o <= 1'b1; // Sticky until reset
      end
    end
  end

endmodule

//--- src/mem_lockstep.sv
// Lockstep checker for a processor data-memory bus
// The reference model pushes expected accesses, the observed bus is compared
// grant by grant and response counts and errors are reported

`timescale 1ns/1ps

module mem_lockstep #(
  parameter int unsigned ExpDepth = 4,
  parameter int unsigned CntWidth = 8
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 exp_valid_i,
  input  logic                 exp_we_i,
  input  logic                 exp_split_i,
  input  lockstep_pkg::addr_t  exp_fst_addr_i,
  input  lockstep_pkg::addr_t  exp_snd_addr_i,
  input  lockstep_pkg::data_t  exp_fst_wdata_i,
  input  lockstep_pkg::data_t  exp_snd_wdata_i,
  input  lockstep_pkg::be_t    exp_fst_be_i,
  input  lockstep_pkg::be_t    exp_snd_be_i,
  input  logic                 data_req_i,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_we_i,
  input  lockstep_pkg::addr_t  data_addr_i,
  input  lockstep_pkg::data_t  data_wdata_i,
  input  lockstep_pkg::be_t    data_be_i,    // Bytes are selected by the expected enables
  output logic                 mismatch_o,
  output logic                 unexpected_o,
  output logic                 done_o,
  output logic [CntWidth-1:0]  outstanding_o,
  output logic [CntWidth-1:0]  mismatch_count_o,
  output logic                 overflow_o,
  output logic                 resp_underflow_o
);
  import lockstep_pkg::*;

  logic  head_valid, head_we, head_split;
  addr_t head_fst_addr, head_snd_addr;
  data_t head_fst_wdata, head_snd_wdata;
  be_t   head_fst_be, head_snd_be;
  logic  pop, grant, fifo_overflow;

  exp_access_fifo #(
    .ExpDepth (ExpDepth)
  ) i_exp_access_fifo (
    .clk_i, .arst_n_i,
    .push_i           (exp_valid_i),
    .we_i             (exp_we_i),
    .split_i          (exp_split_i),
    .fst_addr_i       (exp_fst_addr_i),
    .snd_addr_i       (exp_snd_addr_i),
    .fst_wdata_i      (exp_fst_wdata_i),
    .snd_wdata_i      (exp_snd_wdata_i),
    .fst_be_i         (exp_fst_be_i),
    .snd_be_i         (exp_snd_be_i),
    .pop_i            (pop),
    .head_valid_o     (head_valid),
    .head_we_o        (head_we),
    .head_split_o     (head_split),
    .head_fst_addr_o  (head_fst_addr),
    .head_snd_addr_o  (head_snd_addr),
    .head_fst_wdata_o (head_fst_wdata),
    .head_snd_wdata_o (head_snd_wdata),
    .head_fst_be_o    (head_fst_be),
    .head_snd_be_o    (head_snd_be),
    .overflow_o       (fifo_overflow)
  );

  access_compare i_access_compare (
    .clk_i, .arst_n_i,
    .data_req_i, .data_gnt_i, .data_we_i, .data_addr_i, .data_wdata_i,
    .head_valid_i     (head_valid),
    .head_we_i        (head_we),
    .head_split_i     (head_split),
    .head_fst_addr_i  (head_fst_addr),
    .head_snd_addr_i  (head_snd_addr),
    .head_fst_wdata_i (head_fst_wdata),
    .head_snd_wdata_i (head_snd_wdata),
    .head_fst_be_i    (head_fst_be),
    .head_snd_be_i    (head_snd_be),
    .pop_o            (pop),
    .grant_o          (grant),
    .mismatch_o, .unexpected_o, .done_o
  );

  resp_tracker #(
    .CntWidth (CntWidth)
  ) i_resp_tracker (
    .clk_i, .arst_n_i,
    .grant_i          (grant),
    .rvalid_i         (data_rvalid_i),
    .mismatch_i       (mismatch_o),
    .overflow_i       (fifo_overflow),
    .outstanding_o, .mismatch_count_o, .resp_underflow_o, .overflow_o
  );

endmodule

//--- sim/tb_mem_lockstep.sv
// Self-checking testbench for the data-memory lockstep checker
// A reference model with its own queue predicts every output, concurrent
// assertions compare it with the DUT each clock

`timescale 1ns/1ps

module tb_mem_lockstep;
  import lockstep_pkg::*;

  localparam int unsigned ExpDepth = 4;
  localparam int unsigned CntWidth = 8;

  typedef struct packed {
    logic  we;
    logic  split;
    addr_t fst_addr;
    addr_t snd_addr;
    data_t fst_wdata;
    data_t snd_wdata;
    be_t   fst_be;
    be_t   snd_be;
  } exp_entry_t;

  logic clk_i, arst_n_i;
  logic exp_valid_i, exp_we_i, exp_split_i;
  addr_t exp_fst_addr_i, exp_snd_addr_i;
  data_t exp_fst_wdata_i, exp_snd_wdata_i;
  be_t exp_fst_be_i, exp_snd_be_i;
  logic data_req_i, data_gnt_i, data_rvalid_i, data_we_i;
  addr_t data_addr_i;
  data_t data_wdata_i;
  be_t data_be_i;
  logic mismatch_o, unexpected_o, done_o, overflow_o, resp_underflow_o;
  logic [CntWidth-1:0] outstanding_o, mismatch_count_o;

  // Model state and predicted outputs
  exp_entry_t exp_q[$];
  logic snd_due;
  logic m_mismatch, m_unexpected, m_done, m_overflow, m_underflow;
  logic [CntWidth-1:0] m_outst, m_mcount;

  logic [15:0] lfsr_state = 16'd25581;
  int errors = 0;
  int tests = 0;

  mem_lockstep #(
    .ExpDepth (ExpDepth),
    .CntWidth (CntWidth)
  ) i_mem_lockstep (.*);

  always #50 clk_i = ~clk_i;

  // Galois LFSR, one step per bit
  function automatic data_t rand_word();
    data_t w;
    for (int i = 0; i < DataWidth; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      w[i] = lfsr_state[0];
    end
    return w;
  endfunction

  // Direction, address and enabled bytes of one part
  function automatic logic part_differs(input logic we, input addr_t addr, input data_t wdata,
                                        input be_t be);
    logic diff;
    diff = (data_we_i != we) || (data_addr_i != addr);
    for (int b = 0; b < BeWidth; b++) begin
      if (we && be[b] && data_wdata_i[b*ByteWidth +: ByteWidth] != wdata[b*ByteWidth +: ByteWidth])
        diff = 1'b1;
    end
    return diff;
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin : ref_model
    exp_entry_t head;
    logic gnt, hit, bad, last;
    if (!arst_n_i) begin
      exp_q.delete();
      snd_due = 1'b0;
      {m_mismatch, m_unexpected, m_done, m_overflow, m_underflow} <= '0;
      m_outst  <= '0;
      m_mcount <= '0;
    end else begin
      gnt  = data_req_i && data_gnt_i;
      hit  = gnt && (exp_q.size() != 0);
      bad  = 1'b0;
      last = 1'b0;
      if (hit) begin
        head = exp_q[0];
        last = !head.split || snd_due;
        if (snd_due) bad = part_differs(head.we, head.snd_addr, head.snd_wdata, head.snd_be);
        else bad = part_differs(head.we, head.fst_addr, head.fst_wdata, head.fst_be);
        snd_due = !last;
        if (last) void'(exp_q.pop_front());
      end
      m_mismatch   <= hit && bad;
      m_unexpected <= gnt && !hit;
      m_done       <= hit && last;
      if (exp_valid_i) begin
        if (exp_q.size() < ExpDepth) begin
          exp_q.push_back('{we: exp_we_i, split: exp_split_i, fst_addr: exp_fst_addr_i,
                            snd_addr: exp_snd_addr_i, fst_wdata: exp_fst_wdata_i,
                            snd_wdata: exp_snd_wdata_i, fst_be: exp_fst_be_i,
                            snd_be: exp_snd_be_i});
        end else begin
          m_overflow <= 1'b1;  // Dropped push
        end
      end
      if (gnt && !data_rvalid_i) m_outst <= m_outst + 1'b1;
      else if (!gnt && data_rvalid_i) begin
        if (m_outst == '0) m_underflow <= 1'b1;
        else m_outst <= m_outst - 1'b1;
      end
      if (m_mismatch && m_mcount != '1) m_mcount <= m_mcount + 1'b1;  // Counter trails the pulse
    end
  end

  task automatic report_fail(input string what);
    $display("Fail at %0d ns: %s differs from the expected value", $time, what);
    errors++;
  endtask

  a_mismatch:   assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 mismatch_o == m_mismatch)
                else report_fail("mismatch_o");
  a_unexpected: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 unexpected_o == m_unexpected)
                else report_fail("unexpected_o");
  a_done:       assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 done_o == m_done)
                else report_fail("done_o");
  a_outst:      assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 outstanding_o == m_outst)
                else report_fail("outstanding_o");
  a_mcount:     assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 mismatch_count_o == m_mcount)
                else report_fail("mismatch_count_o");
  a_overflow:   assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 overflow_o == m_overflow)
                else report_fail("overflow_o");
  a_underflow:  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 resp_underflow_o == m_underflow)
                else report_fail("resp_underflow_o");

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation FAILED");
    $finish;
  endtask

  // Called right after a falling edge, like every driving task
  task automatic push_expect(input logic we, input logic split, input addr_t fa, input addr_t sa,
                             input data_t fd, input data_t sd, input be_t fbe, input be_t sbe);
    exp_we_i        = we;
    exp_split_i     = split;
    exp_fst_addr_i  = fa;
    exp_snd_addr_i  = sa;
    exp_fst_wdata_i = fd;
    exp_snd_wdata_i = sd;
    exp_fst_be_i    = fbe;
    exp_snd_be_i    = sbe;
    exp_valid_i = 1'b1;
    @(negedge clk_i);
    exp_valid_i = 1'b0;
  endtask

  task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                            input int gnt_delay);
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_addr_i  = addr;
    data_wdata_i = wdata;
    for (int i = 0; i < gnt_delay; i++) @(negedge clk_i);  // Bus holds the grant back
    data_gnt_i = 1'b1;
    @(negedge clk_i);
    data_req_i = 1'b0;
    data_gnt_i = 1'b0;
  endtask

  task automatic send_rvalid();
    data_rvalid_i = 1'b1;
    @(negedge clk_i);
    data_rvalid_i = 1'b0;
  endtask

  task automatic wait_done(input int max_cycles);
    int n;
    logic seen;
    n = 0;
    seen = done_o;
    while (!seen && n < max_cycles) begin
      @(negedge clk_i);
      seen = done_o;
      n++;
    end
    if (!seen) stop_on_timeout("done_o");
  endtask

  task automatic end_test(input string name, input int err_start);
    repeat (2) @(negedge clk_i);  // Let the trailing counter settle
    tests++;
    $display("Test %0d (%s) finished with %0d errors", tests, name, errors - err_start);
  endtask

  initial begin : stimulus
    data_t wd;
    addr_t ovf_addr [ExpDepth+1];
    int err_start, n;
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    {exp_valid_i, exp_we_i, exp_split_i} = '0;
    {exp_fst_addr_i, exp_snd_addr_i, exp_fst_wdata_i, exp_snd_wdata_i} = '0;
    {exp_fst_be_i, exp_snd_be_i} = '0;
    {data_req_i, data_gnt_i, data_rvalid_i, data_we_i} = '0;
    data_addr_i  = '0;
    data_wdata_i = '0;
    data_be_i    = '1;
    repeat (4) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);

    err_start = errors;
    push_expect(1'b0, 1'b0, 32'h1000, '0, '0, '0, 4'hF, '0);
    bus_access(1'b0, 32'h1000, '0, 0);
    wait_done(8);
    push_expect(1'b0, 1'b0, 32'h1040, '0, '0, '0, 4'hF, '0);
    bus_access(1'b0, 32'h1044, '0, 0);  // Wrong address
    wait_done(8);
    end_test("single read", err_start);

    err_start = errors;
    wd = rand_word();
    push_expect(1'b1, 1'b0, 32'h2000, '0, wd, '0, 4'b0101, '0);
    bus_access(1'b1, 32'h2000, wd ^ 32'hFF00FF00, 0);
    wait_done(8);
    push_expect(1'b1, 1'b0, 32'h2004, '0, wd, '0, 4'b0101, '0);
    bus_access(1'b1, 32'h2004, wd ^ 32'h000000FF, 0);
    wait_done(8);
    end_test("masked write", err_start);

    err_start = errors;
    wd = rand_word();
    push_expect(1'b1, 1'b1, 32'h3002, 32'h3004, wd, ~wd, 4'b1100, 4'b0011);
    bus_access(1'b1, 32'h3002, wd, 0);
    bus_access(1'b1, 32'h3004, ~wd, 1);
    wait_done(8);
    push_expect(1'b0, 1'b1, 32'h3102, 32'h3104, '0, '0, 4'b1100, 4'b0011);
    bus_access(1'b0, 32'h3102, '0, 0);
    bus_access(1'b0, 32'h3108, '0, 0);  // Second part only is wrong
    wait_done(8);
    end_test("split access", err_start);

    err_start = errors;
    bus_access(1'b0, 32'h4000, '0, 0);
    push_expect(1'b0, 1'b0, 32'h4010, '0, '0, '0, 4'hF, '0);
    bus_access(1'b0, 32'h4010, '0, 5);
    wait_done(8);
    end_test("unexpected and delayed grant", err_start);

    err_start = errors;
    n = 0;
    while (outstanding_o != '0 && n < 64) begin
      send_rvalid();
      n++;
    end
    if (outstanding_o != '0) stop_on_timeout("outstanding_o to drain");
    send_rvalid();  // Nothing in flight
    end_test("response count", err_start);

    err_start = errors;
    for (int i = 0; i <= ExpDepth; i++) begin
      ovf_addr[i] = rand_word() & ~32'h3;
      push_expect(1'b0, 1'b0, ovf_addr[i], '0, '0, '0, 4'hF, '0);
    end
    for (int i = 0; i < ExpDepth; i++) begin
      bus_access(1'b0, ovf_addr[i], '0, 0);
      wait_done(8);
    end
    end_test("queue overflow", err_start);

    repeat (3) @(negedge clk_i);
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- mem_lockstep.f
src/lockstep_pkg.sv
src/exp_access_fifo.sv
src/access_compare.sv
src/resp_tracker.sv
src/mem_lockstep.sv
sim/tb_mem_lockstep.sv

//--- Bender.yml
package:
  name: mem_lockstep

sources:
  - target: rtl
    files:
      - src/lockstep_pkg.sv
      - src/exp_access_fifo.sv
      - src/access_compare.sv
      - src/resp_tracker.sv
      - src/mem_lockstep.sv
  - target: test
    files:
      - sim/tb_mem_lockstep.sv
